// ==== verilog/mem_pkg.sv ====
// data memory path shared types
// pipeline request, cache request, bus commands and the word union used
// for byte and halfword lane selection
package mem_pkg;

    // access sizes
    localparam logic [1:0] size_byte = 2'd0;
    localparam logic [1:0] size_half = 2'd1;
    localparam logic [1:0] size_word = 2'd2;

    // load/store request from the pipeline
    typedef struct packed {
        logic        valid;
        logic        is_store;
        logic        is_cacop;
        logic [1:0]  size;
        logic        sign_ext;
        logic [31:0] addr;
        logic [31:0] wdata;      // right-aligned store value
    } mem_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] data;
    } load_resp_t;

    // request into the cache controller
    typedef struct packed {
        logic        valid;
        logic        op;         // 0 read, 1 write
        logic        cacop_en;
        logic [31:0] addr;
        logic [3:0]  awstrb;
        logic [31:0] wdata;      // already in its byte lanes
        logic [31:0] cacop_addr;
    } cache_req_t;

    typedef struct packed {
        logic        rd_req;
        logic [31:0] rd_addr;
    } bus_rd_t;

    typedef struct packed {
        logic        wr_req;
        logic [31:0] wr_addr;
        logic [3:0]  wr_wstrb;
        logic [31:0] wr_data;
    } bus_wr_t;

    typedef struct packed {
        logic        ret_valid;
        logic        ret_last;
        logic [31:0] ret_data;
    } bus_ret_t;

    // one word seen as bytes or as halfwords
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } mem_word_u;

endpackage

// ==== verilog/lsu_request.sv ====
// load/store front end
// builds byte strobes and lane data for stores, and extracts and extends
// the addressed byte or halfword of a returned load word
`timescale 1ns/100ps

module lsu_request (
    input  logic                   clock,
    input  logic                   reset,
    input  mem_pkg::mem_req_t      req,
    output logic                   req_ready,
    output mem_pkg::cache_req_t    cache_req,
    input  logic                   cache_ready,
    input  logic                   rvalid,
    input  logic [31:0]            rdata,
    output mem_pkg::load_resp_t    load_resp,
    output logic                   store_done
);

    logic             accept;
    logic             store_accept;
    logic             load_accept;
    logic             store_stage;
    logic [3:0]       strobe;
    logic [31:0]      lane_data;
    logic [1:0]       ld_size;
    logic             ld_sign;
    logic [1:0]       ld_offset;
    mem_pkg::mem_word_u ret_word;
    logic [7:0]       ret_byte;
    logic [15:0]      ret_half;

    assign req_ready    = cache_ready;
    assign accept       = req.valid && cache_ready;
    assign store_accept = accept && req.is_store && !req.is_cacop;
    assign load_accept  = accept && !req.is_store && !req.is_cacop;

    // strobe picks the live lanes of the replicated data
    always_comb begin
        case (req.size)
            mem_pkg::size_byte: begin
                strobe    = 4'b0001 << req.addr[1:0];
                lane_data = {4{req.wdata[7:0]}};
            end
            mem_pkg::size_half: begin
                strobe    = 4'b0011 << {req.addr[1], 1'b0};
                lane_data = {2{req.wdata[15:0]}};
            end
            mem_pkg::size_word: begin
                strobe    = 4'b1111;
                lane_data = req.wdata;
            end
            default: begin
                strobe    = 4'b0000;
                lane_data = req.wdata;
            end
        endcase
    end

    assign cache_req.valid      = req.valid;
    assign cache_req.op         = req.is_store;
    assign cache_req.cacop_en   = req.is_cacop;
    assign cache_req.addr       = req.addr;
    assign cache_req.awstrb     = strobe;
    assign cache_req.wdata      = lane_data;
    assign cache_req.cacop_addr = req.addr;

    // load format kept until the return beat
    always_ff @(posedge clock) begin
        if (load_accept) begin
            ld_size   <= req.size;
            ld_sign   <= req.sign_ext;
            ld_offset <= req.addr[1:0];
        end
    end

    // store completes two cycles after acceptance once the bus write is done
    always_ff @(posedge clock) begin
        if (reset) begin
            store_stage <= 1'b0;
            store_done  <= 1'b0;
        end else begin
            store_stage <= store_accept;
            store_done  <= store_stage;
        end
    end

    assign ret_word = rdata;
    assign ret_byte = ret_word.bytes[ld_offset];
    assign ret_half = ret_word.halves[ld_offset[1]];

    always_comb begin
        case (ld_size)
            mem_pkg::size_byte: load_resp.data = {{24{ld_sign && ret_byte[7]}}, ret_byte};
            mem_pkg::size_half: load_resp.data = {{16{ld_sign && ret_half[15]}}, ret_half};
            default:            load_resp.data = ret_word;
        endcase
    end

    assign load_resp.valid = rvalid;

    // natural alignment of every accepted load or store
    property p_aligned;
        @(posedge clock) disable iff (reset)
        (req.valid && req_ready && !req.is_cacop) |->
            (req.size != 2'd3) &&
            (req.size != mem_pkg::size_half || req.addr[0] == 1'b0) &&
            (req.size != mem_pkg::size_word || req.addr[1:0] == 2'b00);
    endproperty
    assert property (p_aligned);

endmodule

// ==== verilog/dcache_bypass.sv ====
// uncached data cache controller
// holds one request, issues it as a single-beat bus read or write and
// waits for the return beat on reads; cache operations finish on acceptance
`timescale 1ns/100ps

module dcache_bypass (
    input  logic                   clock,
    input  logic                   reset,
    input  mem_pkg::cache_req_t    cache_req,
    output logic                   ready,
    output logic                   rvalid,
    output logic [31:0]            rdata,
    output mem_pkg::bus_rd_t       bus_rd,
    output mem_pkg::bus_wr_t       bus_wr,
    input  logic                   rd_rdy,
    input  logic                   wr_rdy,
    input  mem_pkg::bus_ret_t      ret
);

    typedef enum logic [1:0] {
        st_idle,
        st_request,
        st_receive,
        st_reset
    } state_t;

    state_t      state;
    logic        req_op;
    logic [31:0] req_addr;
    logic [3:0]  req_awstrb;
    logic [31:0] req_wdata;
    logic        is_read;
    logic        is_write;

    assign ready  = state == st_idle;
    assign rvalid = state == st_receive && ret.ret_last;
    assign rdata  = ret.ret_data;

    assign is_read  = state == st_request && !req_op;
    assign is_write = state == st_request && req_op;

    // addresses read as zero outside the request state
    assign bus_rd.rd_req   = is_read;
    assign bus_rd.rd_addr  = {{30{is_read}}, 2'b00} & req_addr;
    assign bus_wr.wr_req   = is_write;
    assign bus_wr.wr_addr  = {{30{is_write}}, 2'b00} & req_addr;
    assign bus_wr.wr_wstrb = req_awstrb;
    assign bus_wr.wr_data  = req_wdata;

    always_ff @(posedge clock) begin
        if (reset) begin
            state  <= st_reset;
            req_op <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    // cacop is taken and dropped here
                    if (cache_req.valid && !cache_req.cacop_en) begin
                        req_op <= cache_req.op;
                        state  <= st_request;
                    end
                end
                st_request: begin
                    if (req_op && wr_rdy) begin
                        state <= st_idle;
                    end else if (!req_op && rd_rdy) begin
                        state <= st_receive;
                    end
                end
                st_receive: begin
                    if (ret.ret_last) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // captured request payload
    always_ff @(posedge clock) begin
        if (state == st_idle && cache_req.valid && !cache_req.cacop_en) begin
            req_addr   <= {cache_req.addr[31:2], 2'b00};
            req_awstrb <= cache_req.awstrb;
            req_wdata  <= cache_req.wdata;
        end
    end

    // an accepted read is answered by one last beat within the latency range
    assert property (@(posedge clock) disable iff (reset)
        (bus_rd.rd_req && rd_rdy) |=> ##[1:8] (ret.ret_valid && ret.ret_last));

    // a return beat only ever answers our own outstanding read
    assert property (@(posedge clock) disable iff (reset)
        ret.ret_valid |-> state == st_receive);

endmodule

// ==== verilog/data_ram.sv ====
// on-chip data RAM bus responder
// single-beat reads returned after a fixed latency, byte-strobed writes
// completing in the cycle they are accepted
`timescale 1ns/100ps

module data_ram #(
    parameter int ram_words    = 1024,
    parameter int read_latency = 2
) (
    input  logic                 clock,
    input  logic                 reset,
    input  mem_pkg::bus_rd_t     bus_rd,
    input  mem_pkg::bus_wr_t     bus_wr,
    output logic                 rd_rdy,
    output logic                 wr_rdy,
    output mem_pkg::bus_ret_t    ret
);

    localparam int idx_w = $clog2(ram_words);
    localparam int cnt_w = $clog2(read_latency + 1);

    mem_pkg::mem_word_u mem [ram_words];

    logic [cnt_w-1:0]   pending;
    logic [idx_w-1:0]   rd_idx;
    logic [idx_w-1:0]   wr_idx;
    mem_pkg::mem_word_u wr_word;
    mem_pkg::mem_word_u ret_word;
    logic               ret_beat;

    // power-up contents are zero
    initial begin
        for (int i = 0; i < ram_words; i++) begin
            mem[i] = '0;
        end
    end

    assign rd_rdy  = pending == '0;
    assign wr_rdy  = pending == '0;
    assign wr_idx  = bus_wr.wr_addr[idx_w+1:2];
    assign wr_word = bus_wr.wr_data;

    always_ff @(posedge clock) begin
        if (bus_wr.wr_req && wr_rdy) begin
            for (int i = 0; i < 4; i++) begin
                if (bus_wr.wr_wstrb[i]) begin
                    mem[wr_idx].bytes[i] <= wr_word.bytes[i];
                end
            end
        end
    end

    // beat goes out as the latency counter runs out
    always_ff @(posedge clock) begin
        if (reset) begin
            pending  <= '0;
            ret_beat <= 1'b0;
        end else begin
            ret_beat <= pending == cnt_w'(1);
            if (bus_rd.rd_req && rd_rdy) begin
                pending <= cnt_w'(read_latency);
            end else if (pending != '0) begin
                pending <= pending - 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (bus_rd.rd_req && rd_rdy) begin
            rd_idx <= bus_rd.rd_addr[idx_w+1:2];
        end
        if (pending == cnt_w'(1)) begin
            ret_word <= mem[rd_idx];
        end
    end

    assign ret.ret_valid = ret_beat;
    assign ret.ret_last  = ret_beat;
    assign ret.ret_data  = ret_word;

    // no aliasing of addresses past the end of the array
    assert property (@(posedge clock) disable iff (reset)
        (bus_rd.rd_req |-> bus_rd.rd_addr[31:2] < ram_words) and
        (bus_wr.wr_req |-> bus_wr.wr_addr[31:2] < ram_words));

endmodule

// ==== verilog/data_mem_subsystem.sv ====
// data memory subsystem top
// load/store front end, uncached cache controller and data RAM in series
`timescale 1ns/100ps

module data_mem_subsystem #(
    parameter int ram_words    = 1024,
    parameter int read_latency = 2
) (
    input  logic                   clock,
    input  logic                   reset,
    input  mem_pkg::mem_req_t      req,
    output logic                   req_ready,
    output mem_pkg::load_resp_t    load_resp,
    output logic                   store_done
);

    mem_pkg::cache_req_t cache_req;
    logic                cache_ready;
    logic                rvalid;
    logic [31:0]         rdata;
    mem_pkg::bus_rd_t    bus_rd;
    mem_pkg::bus_wr_t    bus_wr;
    logic                rd_rdy;
    logic                wr_rdy;
    mem_pkg::bus_ret_t   ret;

    lsu_request u_lsu (
        .clock       (clock),
        .reset       (reset),
        .req         (req),
        .req_ready   (req_ready),
        .cache_req   (cache_req),
        .cache_ready (cache_ready),
        .rvalid      (rvalid),
        .rdata       (rdata),
        .load_resp   (load_resp),
        .store_done  (store_done)
    );

    dcache_bypass u_dcache (
        .clock     (clock),
        .reset     (reset),
        .cache_req (cache_req),
        .ready     (cache_ready),
        .rvalid    (rvalid),
        .rdata     (rdata),
        .bus_rd    (bus_rd),
        .bus_wr    (bus_wr),
        .rd_rdy    (rd_rdy),
        .wr_rdy    (wr_rdy),
        .ret       (ret)
    );

    data_ram #(
        .ram_words    (ram_words),
        .read_latency (read_latency)
    ) u_ram (
        .clock  (clock),
        .reset  (reset),
        .bus_rd (bus_rd),
        .bus_wr (bus_wr),
        .rd_rdy (rd_rdy),
        .wr_rdy (wr_rdy),
        .ret    (ret)
    );

endmodule

// ==== tb/data_mem_subsystem_tb.sv ====
// testbench for the data memory subsystem
// random byte, halfword and word loads and stores plus cache operations,
// checked against a byte-array model of the RAM
`timescale 1ns/100ps

module data_mem_subsystem_tb;

    localparam int ram_words    = 256;
    localparam int read_latency = 3;
    localparam int word_tests   = 64;
    localparam int mixed_tests  = 200;
    localparam int num_requests = 2 * word_tests + mixed_tests;
    localparam int cycle_limit  = num_requests * (read_latency + 8) + 100;

    logic                clock;
    logic                reset;
    mem_pkg::mem_req_t   req;
    logic                req_ready;
    mem_pkg::load_resp_t load_resp;
    logic                store_done;

    logic [7:0]  model [ram_words*4];
    logic [31:0] word_addrs [word_tests];
    int          cycles;

    data_mem_subsystem #(
        .ram_words    (ram_words),
        .read_latency (read_latency)
    ) uut (
        .clock      (clock),
        .reset      (reset),
        .req        (req),
        .req_ready  (req_ready),
        .load_resp  (load_resp),
        .store_done (store_done)
    );

    always #50 clock = ~clock;

    // run limit
    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("tests failed");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %s: expected %h, actual %h", name, expected, actual);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    // little-endian view of the model at a naturally aligned address
    function automatic logic [31:0] expected_load(input logic [31:0] addr,
                                                  input logic [1:0] size,
                                                  input logic sign_ext);
        int a;
        logic [15:0] half;
        a = addr;
        half = {model[a+1], model[a]};
        case (size)
            mem_pkg::size_byte: return {{24{sign_ext && model[a][7]}}, model[a]};
            mem_pkg::size_half: return {{16{sign_ext && half[15]}}, half};
            default:            return {model[a+3], model[a+2], model[a+1], model[a]};
        endcase
    endfunction

    task automatic update_model(input logic [31:0] addr, input logic [1:0] size,
                                input logic [31:0] wdata);
        int a;
        int n;
        a = addr;
        n = (size == mem_pkg::size_byte) ? 1 : (size == mem_pkg::size_half) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            model[a+i] = wdata[8*i +: 8];
        end
    endtask

    // drives one request and waits for its completion
    task automatic run_request(input string name, input logic is_store,
                               input logic is_cacop, input logic [1:0] size,
                               input logic sign_ext, input logic [31:0] addr,
                               input logic [31:0] wdata);
        mem_pkg::mem_req_t r;
        logic [31:0]       expected;
        logic              done;
        r.valid    = 1'b1;
        r.is_store = is_store;
        r.is_cacop = is_cacop;
        r.size     = size;
        r.sign_ext = sign_ext;
        r.addr     = addr;
        r.wdata    = wdata;
        @(posedge clock);
        req <= r;
        done = 1'b0;
        while (!done) begin
            @(negedge clock);
            check_value({name, " store_done while idle"}, 32'd0, store_done);
            check_value({name, " load valid while idle"}, 32'd0, load_resp.valid);
            done = req_ready;
        end
        // acceptance edge
        @(posedge clock);
        req <= '0;
        if (is_cacop) begin
            // controller stays idle with no completion
            @(negedge clock);
            check_value({name, " req_ready after cacop"}, 32'd1, req_ready);
            check_value({name, " store_done on cacop"}, 32'd0, store_done);
            check_value({name, " load valid on cacop"}, 32'd0, load_resp.valid);
        end else begin
            expected = expected_load(addr, size, sign_ext);
            if (is_store) begin
                update_model(addr, size, wdata);
            end
            done = 1'b0;
            while (!done) begin
                @(negedge clock);
                if (is_store) begin
                    check_value({name, " load valid on store"}, 32'd0, load_resp.valid);
                    done = store_done;
                end else begin
                    check_value({name, " store_done on load"}, 32'd0, store_done);
                    done = load_resp.valid;
                end
                if (!done) begin
                    check_value({name, " req_ready while busy"}, 32'd0, req_ready);
                end
            end
            if (!is_store) begin
                check_value(name, expected, load_resp.data);
            end
        end
    endtask

    initial begin
        logic [1:0]  size;
        logic [31:0] addr;
        int          kind;
        void'($urandom(32'hf4d57aad));
        clock  = 1'b0;
        reset  = 1'b1;
        req    = '0;
        cycles = 0;
        for (int i = 0; i < ram_words * 4; i++) begin
            model[i] = 8'h00;
        end

        repeat (3) @(posedge clock);
        reset <= 1'b0;

        // controller spends one cycle in its reset state
        @(negedge clock);
        check_value("reset req_ready", 32'd0, req_ready);
        check_value("reset load valid", 32'd0, load_resp.valid);
        check_value("reset store_done", 32'd0, store_done);
        for (int i = 0; i < 2 && !req_ready; i++) begin
            @(negedge clock);
        end
        check_value("req_ready after reset", 32'd1, req_ready);

        for (int i = 0; i < word_tests; i++) begin
            word_addrs[i] = ($urandom % ram_words) << 2;
            run_request($sformatf("word store %0d", i), 1'b1, 1'b0, mem_pkg::size_word,
                        1'b0, word_addrs[i], $urandom);
        end
        for (int i = 0; i < word_tests; i++) begin
            run_request($sformatf("word load %0d", i), 1'b0, 1'b0, mem_pkg::size_word,
                        1'b0, word_addrs[i], 32'd0);
        end

        // mixed sizes with the odd cache operation
        for (int i = 0; i < mixed_tests; i++) begin
            kind = $urandom % 8;
            size = $urandom % 3;
            addr = $urandom % (ram_words * 4);
            if (size == mem_pkg::size_half) begin
                addr[0] = 1'b0;
            end else if (size == mem_pkg::size_word) begin
                addr[1:0] = 2'b00;
            end
            if (kind == 0) begin
                run_request($sformatf("cacop %0d", i), 1'b0, 1'b1, mem_pkg::size_word,
                            1'b0, {addr[31:2], 2'b00}, $urandom);
            end else if (kind < 4) begin
                run_request($sformatf("mixed store %0d", i), 1'b1, 1'b0, size,
                            1'b0, addr, $urandom);
            end else begin
                run_request($sformatf("mixed load %0d", i), 1'b0, 1'b0, size,
                            $urandom % 2, addr, 32'd0);
            end
        end

        // no late completion after the last request
        repeat (read_latency + 3) begin
            @(negedge clock);
            check_value("final store_done", 32'd0, store_done);
            check_value("final load valid", 32'd0, load_resp.valid);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== files.f ====
verilog/mem_pkg.sv
verilog/lsu_request.sv
verilog/dcache_bypass.sv
verilog/data_ram.sv
verilog/data_mem_subsystem.sv
tb/data_mem_subsystem_tb.sv

// ==== Bender.yml ====
package:
  name: data_mem_subsystem

sources:
  - verilog/mem_pkg.sv
  - verilog/lsu_request.sv
  - verilog/dcache_bypass.sv
  - verilog/data_ram.sv
  - verilog/data_mem_subsystem.sv
  - target: test
    files:
      - tb/data_mem_subsystem_tb.sv
